/* Makefile */
LOG = sim.log

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert -f all.f --top-module tb_issue_stage

sim:
	verilator --binary --timing --assert -Wno-fatal -f all.f \
		--top-module tb_issue_stage -o sim_issue_stage
	./obj_dir/sim_issue_stage | tee $(LOG)
	grep -q "TEST PASSED" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

/* all.f */
source/isa_pkg.sv
source/issue_pkg.sv
source/issue_queue.sv
source/instr_decoder.sv
source/operand_resolver.sv
source/issue_control.sv
source/issue_stage.sv
test/issue_stage_assertions.sv
test/tb_issue_stage.sv

/* source/instr_decoder.sv */
`timescale 1ns/1ps

module instr_decoder
    import isa_pkg::*, issue_pkg::*;
(
    input  instr_t                 instr_i,
    output logic [EU_N-1:0]        eu_sel_o,    // One-hot target unit, zero for ROB only
    output logic [EU_CTL_LEN-1:0]  eu_ctl_o,
    output logic [XLEN-1:0]        imm_o,
    output logic [REG_IDX_LEN-1:0] rs1_idx_o,
    output logic [REG_IDX_LEN-1:0] rs2_idx_o,
    output logic [REG_IDX_LEN-1:0] rd_idx_o,
    output logic                   rs1_used_o,
    output logic                   rs2_used_o,
    output logic                   illegal_o,
    output logic                   serial_o
);

    logic [XLEN-1:0] imm_i_type, imm_s_type, imm_b_type, imm_u_type;

    // --------------------------------------------------
    // Immediates, sign-extended
    // --------------------------------------------------
    assign imm_i_type = {{20{instr_i.i_fmt.imm12[11]}}, instr_i.i_fmt.imm12};
    assign imm_s_type = {{20{instr_i.s_fmt.imm_hi[6]}}, instr_i.s_fmt.imm_hi,
                         instr_i.s_fmt.imm_lo};
    assign imm_b_type = {{19{instr_i.s_fmt.imm_hi[6]}}, instr_i.s_fmt.imm_hi[6],
                         instr_i.s_fmt.imm_lo[0], instr_i.s_fmt.imm_hi[5:0],
                         instr_i.s_fmt.imm_lo[4:1], 1'b0};  // imm[0] always zero
    assign imm_u_type = {instr_i.u_fmt.imm20, 12'b0};

    // --------------------------------------------------
    // Opcode decode
    // --------------------------------------------------
    always_comb begin
        // Defaults cover the ROB-only cases
        eu_sel_o   = '0;
        eu_ctl_o   = {1'b0, instr_i.r_fmt.funct3};
        imm_o      = '0;
        rd_idx_o   = instr_i.r_fmt.rd;
        rs1_used_o = 1'b0;
        rs2_used_o = 1'b0;
        illegal_o  = 1'b0;
        serial_o   = 1'b0;
        unique case (instr_i.r_fmt.opcode)
            OPC_OP: begin
                eu_sel_o[EU_ALU] = 1'b1;
                eu_ctl_o   = {instr_i.r_fmt.funct7[5], instr_i.r_fmt.funct3};  // SUB/SRA flag
                rs1_used_o = 1'b1;
                rs2_used_o = 1'b1;
            end
            OPC_OP_IMM: begin
                eu_sel_o[EU_ALU] = 1'b1;
                imm_o      = imm_i_type;
                rs1_used_o = 1'b1;
            end
            OPC_LUI: begin
                eu_sel_o[EU_ALU] = 1'b1;
                imm_o = imm_u_type;
            end
            OPC_LOAD: begin
                eu_sel_o[EU_LSU] = 1'b1;
                imm_o      = imm_i_type;
                rs1_used_o = 1'b1;
            end
            OPC_STORE: begin
                eu_sel_o[EU_LSU] = 1'b1;
                eu_ctl_o   = {1'b1, instr_i.s_fmt.funct3};  // High bit marks a store
                imm_o      = imm_s_type;
                rd_idx_o   = '0;                           // No destination
                rs1_used_o = 1'b1;
                rs2_used_o = 1'b1;
            end
            OPC_BRANCH: begin
                eu_sel_o[EU_BRANCH] = 1'b1;
                imm_o      = imm_b_type;
                rd_idx_o   = '0;
                rs1_used_o = 1'b1;
                rs2_used_o = 1'b1;
            end
            OPC_SYSTEM, OPC_FENCE: begin
                serial_o = 1'b1;        // Handled at commit, ROB only
                imm_o    = imm_i_type;  // CSR address or fence bits
            end
            default: begin
                illegal_o = 1'b1;
                rd_idx_o  = '0;
            end
        endcase
    end

    // Unused sources read as x0
    assign rs1_idx_o = rs1_used_o ? instr_i.r_fmt.rs1 : '0;
    assign rs2_idx_o = rs2_used_o ? instr_i.r_fmt.rs2 : '0;

endmodule

/* source/isa_pkg.sv */
package isa_pkg;

    // --------------------------------------------------
    // Word widths
    // --------------------------------------------------
    localparam int XLEN        = 32;  // Data and PC width
    localparam int ILEN        = 32;  // Instruction width
    localparam int REG_IDX_LEN = 5;   // x0..x31

    // --------------------------------------------------
    // Major opcodes (RV32I base)
    // --------------------------------------------------
    localparam logic [6:0] OPC_OP     = 7'b0110011;  // Register-register ALU
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;  // Register-immediate ALU
    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_LOAD   = 7'b0000011;
    localparam logic [6:0] OPC_STORE  = 7'b0100011;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;
    localparam logic [6:0] OPC_SYSTEM = 7'b1110011;  // CSR, ECALL, EBREAK, xRET
    localparam logic [6:0] OPC_FENCE  = 7'b0001111;

    // One instruction word seen through each base format
    // B immediates come from the s_fmt fields
    typedef union packed {
        struct packed {
            logic [6:0]             funct7;
            logic [REG_IDX_LEN-1:0] rs2;
            logic [REG_IDX_LEN-1:0] rs1;
            logic [2:0]             funct3;
            logic [REG_IDX_LEN-1:0] rd;
            logic [6:0]             opcode;
        } r_fmt;
        struct packed {
            logic [11:0]            imm12;
            logic [REG_IDX_LEN-1:0] rs1;
            logic [2:0]             funct3;
            logic [REG_IDX_LEN-1:0] rd;
            logic [6:0]             opcode;
        } i_fmt;
        struct packed {
            logic [6:0]             imm_hi;   // imm[11:5]
            logic [REG_IDX_LEN-1:0] rs2;
            logic [REG_IDX_LEN-1:0] rs1;
            logic [2:0]             funct3;
            logic [4:0]             imm_lo;   // imm[4:0]
            logic [6:0]             opcode;
        } s_fmt;
        struct packed {
            logic [19:0]            imm20;    // imm[31:12]
            logic [REG_IDX_LEN-1:0] rd;
            logic [6:0]             opcode;
        } u_fmt;
    } instr_t;

endpackage

/* source/issue_control.sv */
`timescale 1ns/1ps

module issue_control
    import issue_pkg::*;
(
    input  logic            clk_i,
    input  logic            rst_i,
    input  logic            flush_i,
    input  logic            resume_i,      // Commit retired the serializing instruction
    input  logic            empty_i,
    input  logic [EU_N-1:0] eu_sel_i,
    input  logic            illegal_i,
    input  logic            serial_i,
    input  logic            rob_ready_i,
    input  logic [EU_N-1:0] ex_ready_i,
    output logic            rob_valid_o,
    output logic [EU_N-1:0] ex_valid_o,
    output logic            pop_o,
    output logic            stalled_o
);

    logic stall_q;
    logic head_ok;     // Head present and issue allowed
    logic rob_only;    // No unit needed
    logic eu_ready;    // Selected unit can take it
    logic issue;

    assign head_ok  = !empty_i && !stall_q && !flush_i;  // Flushed head never leaves
    assign rob_only = illegal_i || serial_i || (eu_sel_i == '0);
    assign eu_ready = |(eu_sel_i & ex_ready_i);

    // --------------------------------------------------
    // Dispatch handshakes
    // --------------------------------------------------
    // Both valids follow the head alone
    assign rob_valid_o = head_ok;
    assign ex_valid_o  = eu_sel_i & {EU_N{head_ok && !rob_only}};

    // Issue needs the ROB and the selected unit ready in the same cycle
    assign issue = head_ok && rob_ready_i && (rob_only || eu_ready);
    assign pop_o = issue;

    // --------------------------------------------------
    // Serializing stall
    // --------------------------------------------------
    always_ff @(posedge clk_i) begin
        if (rst_i || flush_i) begin
            stall_q <= 1'b0;
        end else if (issue && serial_i) begin
            stall_q <= 1'b1;  // Hold younger instructions back
        end else if (resume_i) begin
            stall_q <= 1'b0;
        end
    end

    assign stalled_o = stall_q;

endmodule

/* source/issue_pkg.sv */
package issue_pkg;

    // --------------------------------------------------
    // Issue stage sizes
    // --------------------------------------------------
    localparam int IQ_DEPTH    = 4;  // Issue queue entries
    localparam int ROB_IDX_LEN = 3;  // 8 ROB entries

    // --------------------------------------------------
    // Execution units
    // --------------------------------------------------
    localparam int EU_N      = 3;   // Number of units, one valid/ready pair each
    localparam int EU_ALU    = 0;   // Integer ALU
    localparam int EU_BRANCH = 1;   // Branch unit
    localparam int EU_LSU    = 2;   // Load/store unit

    // Unit control word
    // Bit 3 is funct7[5] for OP, the store flag for the LSU
    // Bits 2:0 carry funct3
    localparam int EU_CTL_LEN = 4;

endpackage

/* source/issue_queue.sv */
`timescale 1ns/1ps

module issue_queue
    import isa_pkg::*, issue_pkg::*;
#(
    parameter int DEPTH = IQ_DEPTH
) (
    input  logic            clk_i,
    input  logic            rst_i,
    input  logic            flush_i,
    input  logic            push_i,
    output logic            full_o,
    input  logic [XLEN-1:0] pc_i,
    input  logic [ILEN-1:0] instr_i,
    input  logic            pop_i,
    output logic            empty_o,
    output logic [XLEN-1:0] pc_o,
    output logic [ILEN-1:0] instr_o
);

    localparam int PTR_LEN = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_LEN = $clog2(DEPTH + 1);

    logic [XLEN-1:0]    pc_mem    [DEPTH];  // Payload storage, no reset
    logic [ILEN-1:0]    instr_mem [DEPTH];
    logic [PTR_LEN-1:0] wr_ptr, rd_ptr;
    logic [CNT_LEN-1:0] count;
    logic               do_push, do_pop;

    assign full_o  = (count == CNT_LEN'(DEPTH));
    assign empty_o = (count == '0);
    assign do_push = push_i && !full_o;   // Drop pushes into a full queue
    assign do_pop  = pop_i && !empty_o;

    // Head is read straight from storage
    assign pc_o    = pc_mem[rd_ptr];
    assign instr_o = instr_mem[rd_ptr];

    // --------------------------------------------------
    // Pointers and occupancy
    // --------------------------------------------------
    always_ff @(posedge clk_i) begin
        if (rst_i || flush_i) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) wr_ptr <= (wr_ptr == PTR_LEN'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            if (do_pop)  rd_ptr <= (rd_ptr == PTR_LEN'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            if (do_push && !do_pop)      count <= count + 1'b1;
            else if (do_pop && !do_push) count <= count - 1'b1;
            // Push and pop together keep the count
        end
    end

    always_ff @(posedge clk_i) begin
        if (do_push) begin
            pc_mem[wr_ptr]    <= pc_i;
            instr_mem[wr_ptr] <= instr_i;
        end
    end

endmodule

/* source/issue_stage.sv */
`timescale 1ns/1ps

module issue_stage
    import isa_pkg::*, issue_pkg::*;
(
    input  logic                   clk_i,
    input  logic                   rst_i,
    input  logic                   flush_i,
    input  logic                   resume_i,
    // Fetch
    input  logic                   fetch_valid_i,
    output logic                   fetch_ready_o,
    input  logic [XLEN-1:0]        fetch_pc_i,
    input  logic [ILEN-1:0]        fetch_instr_i,
    // Register status and register file
    input  logic                   rs1_busy_i,
    input  logic [ROB_IDX_LEN-1:0] rs1_rob_idx_i,
    input  logic                   rs2_busy_i,
    input  logic [ROB_IDX_LEN-1:0] rs2_rob_idx_i,
    output logic [REG_IDX_LEN-1:0] rs1_idx_o,      // Shared by status and RF lookup
    output logic [REG_IDX_LEN-1:0] rs2_idx_o,
    input  logic [XLEN-1:0]        rf_rs1_value_i,
    input  logic [XLEN-1:0]        rf_rs2_value_i,
    // ROB
    input  logic                   rob_ready_i,
    output logic                   rob_valid_o,
    input  logic [ROB_IDX_LEN-1:0] rob_tail_idx_i,
    input  logic                   rob_rs1_ready_i,
    input  logic [XLEN-1:0]        rob_rs1_value_i,
    input  logic                   rob_rs2_ready_i,
    input  logic [XLEN-1:0]        rob_rs2_value_i,
    output logic [REG_IDX_LEN-1:0] rob_rd_idx_o,
    output logic                   rob_illegal_o,
    output logic                   rob_serial_o,
    // CDB
    input  logic                   cdb_valid_i,
    input  logic [ROB_IDX_LEN-1:0] cdb_rob_idx_i,
    input  logic [XLEN-1:0]        cdb_value_i,
    // Execution units
    input  logic [EU_N-1:0]        ex_ready_i,
    output logic [EU_N-1:0]        ex_valid_o,
    output logic [EU_CTL_LEN-1:0]  ex_eu_ctl_o,
    output logic                   ex_rs1_ready_o,
    output logic [ROB_IDX_LEN-1:0] ex_rs1_tag_o,
    output logic [XLEN-1:0]        ex_rs1_value_o,
    output logic                   ex_rs2_ready_o,
    output logic [ROB_IDX_LEN-1:0] ex_rs2_tag_o,
    output logic [XLEN-1:0]        ex_rs2_value_o,
    output logic [XLEN-1:0]        ex_imm_o,
    output logic [ROB_IDX_LEN-1:0] ex_rob_idx_o,
    output logic [XLEN-1:0]        ex_pc_o
);

    logic            iq_push, iq_pop, iq_full, iq_empty;
    instr_t          iq_instr;   // Queue head word
    logic [EU_N-1:0] dec_eu_sel;
    logic            rs1_used, rs2_used;
    logic            stalled;

    // --------------------------------------------------
    // Fetch side
    // --------------------------------------------------
    assign fetch_ready_o = !iq_full && !stalled;
    assign iq_push       = fetch_valid_i && fetch_ready_o;  // Dropped by the queue on flush

    issue_queue #(.DEPTH(IQ_DEPTH)) u_issue_queue (
        .clk_i   (clk_i),
        .rst_i   (rst_i),
        .flush_i (flush_i),
        .push_i  (iq_push),
        .full_o  (iq_full),
        .pc_i    (fetch_pc_i),
        .instr_i (fetch_instr_i),
        .pop_i   (iq_pop),
        .empty_o (iq_empty),
        .pc_o    (ex_pc_o),
        .instr_o (iq_instr)
    );

    instr_decoder u_instr_decoder (
        .instr_i    (iq_instr),
        .eu_sel_o   (dec_eu_sel),
        .eu_ctl_o   (ex_eu_ctl_o),
        .imm_o      (ex_imm_o),
        .rs1_idx_o  (rs1_idx_o),
        .rs2_idx_o  (rs2_idx_o),
        .rd_idx_o   (rob_rd_idx_o),
        .rs1_used_o (rs1_used),
        .rs2_used_o (rs2_used),
        .illegal_o  (rob_illegal_o),
        .serial_o   (rob_serial_o)
    );

    // --------------------------------------------------
    // Operands, unused sources forced ready
    // --------------------------------------------------
    operand_resolver u_rs1_resolver (
        .busy_i        (rs1_busy_i && rs1_used),
        .rob_idx_i     (rs1_rob_idx_i),
        .rf_value_i    (rf_rs1_value_i),
        .rob_ready_i   (rob_rs1_ready_i),
        .rob_value_i   (rob_rs1_value_i),
        .cdb_valid_i   (cdb_valid_i),
        .cdb_rob_idx_i (cdb_rob_idx_i),
        .cdb_value_i   (cdb_value_i),
        .ready_o       (ex_rs1_ready_o),
        .tag_o         (ex_rs1_tag_o),
        .value_o       (ex_rs1_value_o)
    );

    operand_resolver u_rs2_resolver (
        .busy_i        (rs2_busy_i && rs2_used),
        .rob_idx_i     (rs2_rob_idx_i),
        .rf_value_i    (rf_rs2_value_i),
        .rob_ready_i   (rob_rs2_ready_i),
        .rob_value_i   (rob_rs2_value_i),
        .cdb_valid_i   (cdb_valid_i),
        .cdb_rob_idx_i (cdb_rob_idx_i),
        .cdb_value_i   (cdb_value_i),
        .ready_o       (ex_rs2_ready_o),
        .tag_o         (ex_rs2_tag_o),
        .value_o       (ex_rs2_value_o)
    );

    issue_control u_issue_control (
        .clk_i       (clk_i),
        .rst_i       (rst_i),
        .flush_i     (flush_i),
        .resume_i    (resume_i),
        .empty_i     (iq_empty),
        .eu_sel_i    (dec_eu_sel),
        .illegal_i   (rob_illegal_o),
        .serial_i    (rob_serial_o),
        .rob_ready_i (rob_ready_i),
        .ex_ready_i  (ex_ready_i),
        .rob_valid_o (rob_valid_o),
        .ex_valid_o  (ex_valid_o),
        .pop_o       (iq_pop),
        .stalled_o   (stalled)
    );

    assign ex_rob_idx_o = rob_tail_idx_i;  // Entry allocated by this issue

endmodule

/* source/operand_resolver.sv */
`timescale 1ns/1ps

module operand_resolver
    import isa_pkg::*, issue_pkg::*;
(
    input  logic                   busy_i,         // Register waits for an in-flight producer
    input  logic [ROB_IDX_LEN-1:0] rob_idx_i,      // Producer ROB entry
    input  logic [XLEN-1:0]        rf_value_i,
    input  logic                   rob_ready_i,    // Producer result already in the ROB
    input  logic [XLEN-1:0]        rob_value_i,
    input  logic                   cdb_valid_i,
    input  logic [ROB_IDX_LEN-1:0] cdb_rob_idx_i,
    input  logic [XLEN-1:0]        cdb_value_i,
    output logic                   ready_o,
    output logic [ROB_IDX_LEN-1:0] tag_o,
    output logic [XLEN-1:0]        value_o
);

    logic cdb_hit;

    assign cdb_hit = cdb_valid_i && (cdb_rob_idx_i == rob_idx_i);  // Result broadcast right now
    assign tag_o   = rob_idx_i;  // Only meaningful while not ready

    // --------------------------------------------------
    // Source priority RF > ROB > CDB
    // --------------------------------------------------
    always_comb begin
        if (!busy_i) begin
            ready_o = 1'b1;
            value_o = rf_value_i;   // Architectural value is current
        end else if (rob_ready_i) begin
            ready_o = 1'b1;
            value_o = rob_value_i;  // Computed, not yet committed
        end else if (cdb_hit) begin
            ready_o = 1'b1;
            value_o = cdb_value_i;
        end else begin
            ready_o = 1'b0;         // Unit snoops the CDB for tag_o
            value_o = '0;
        end
    end

endmodule

/* test/issue_stage_assertions.sv */
`timescale 1ns/1ps

module issue_stage_assertions
    import isa_pkg::*, issue_pkg::*;
(
    input logic                 clk_i,
    input logic                 rst_i,
    input logic                 flush_i,
    input logic                 resume_i,
    input logic                 fetch_ready_o,
    input logic                 rob_valid_o,
    input logic                 rob_ready_i,
    input logic                 rob_illegal_o,
    input logic                 rob_serial_o,
    input logic [EU_N-1:0]      ex_valid_o,
    input logic [EU_N-1:0]      ex_ready_i,
    input logic [XLEN-1:0]      ex_pc_o,
    input logic [XLEN-1:0]      ex_imm_o
);

    int   assert_errors = 0;  // Read by the testbench at the end of the run
    logic issue;              // ROB and the needed unit both take the head
    logic serial_wait;        // Serializing word issued, no resume yet

    assign issue = rob_valid_o && rob_ready_i
                   && (ex_valid_o == '0 || (ex_valid_o & ex_ready_i) != '0);

    always_ff @(posedge clk_i) begin
        if (rst_i || flush_i) begin
            serial_wait <= 1'b0;
        end else if (issue && rob_serial_o) begin
            serial_wait <= 1'b1;
        end else if (resume_i) begin
            serial_wait <= 1'b0;
        end
    end

    // --------------------------------------------------
    // Dispatch pairing
    // --------------------------------------------------
    a_one_unit: assert property (@(posedge clk_i) disable iff (rst_i) $onehot0(ex_valid_o))
        else begin $error("more than one unit valid"); assert_errors++; end

    a_unit_with_rob: assert property (@(posedge clk_i) disable iff (rst_i)
        (|ex_valid_o) |-> rob_valid_o)
        else begin $error("unit valid without ROB valid"); assert_errors++; end

    a_rob_with_unit: assert property (@(posedge clk_i) disable iff (rst_i)
        (rob_valid_o && !rob_illegal_o && !rob_serial_o) |-> (ex_valid_o != '0))
        else begin $error("ROB valid without unit valid"); assert_errors++; end

    // Illegal and serializing words go to the ROB alone
    a_rob_only: assert property (@(posedge clk_i) disable iff (rst_i)
        (rob_valid_o && (rob_illegal_o || rob_serial_o)) |-> (ex_valid_o == '0))
        else begin $error("ROB-only word sent to a unit"); assert_errors++; end

    // --------------------------------------------------
    // Back-pressure, stall and flush
    // --------------------------------------------------
    a_head_hold: assert property (@(posedge clk_i) disable iff (rst_i)
        (rob_valid_o && !issue && !flush_i) |=> ($stable(ex_pc_o) && $stable(ex_imm_o)))
        else begin $error("head moved without an issue"); assert_errors++; end

    a_stall_blocks: assert property (@(posedge clk_i) disable iff (rst_i)
        serial_wait |-> !rob_valid_o && !fetch_ready_o)
        else begin $error("issue or fetch during stall"); assert_errors++; end

    a_flush_ready: assert property (@(posedge clk_i) disable iff (rst_i)
        flush_i |=> fetch_ready_o)
        else begin $error("fetch not ready after flush"); assert_errors++; end

endmodule

/* test/tb_issue_stage.sv */
`timescale 1ns/1ps

module tb_issue_stage
    import isa_pkg::*, issue_pkg::*;
;

    localparam int PERIOD     = 4;
    localparam int N_RANDOM   = 24;                   // Instructions in the random test
    localparam int CYC_TOTAL  = N_RANDOM * 16 + 40 + 40 + 30 + 100;  // Tests plus margin
    localparam int WATCHDOG   = CYC_TOTAL * PERIOD;

    logic clk_i = 0, rst_i = 1, flush_i = 0, resume_i = 0;
    logic fetch_valid_i = 0, fetch_ready_o;
    logic [XLEN-1:0] fetch_pc_i = '0;
    logic [ILEN-1:0] fetch_instr_i = '0;
    logic rs1_busy_i = 0, rs2_busy_i = 0;
    logic [ROB_IDX_LEN-1:0] rs1_rob_idx_i = '0, rs2_rob_idx_i = '0, rob_tail_idx_i = '0;
    logic [REG_IDX_LEN-1:0] rs1_idx_o, rs2_idx_o, rob_rd_idx_o;
    logic [XLEN-1:0] rf_rs1_value_i = '0, rf_rs2_value_i = '0;
    logic rob_ready_i = 0, rob_valid_o, rob_illegal_o, rob_serial_o;
    logic rob_rs1_ready_i = 0, rob_rs2_ready_i = 0;
    logic [XLEN-1:0] rob_rs1_value_i = '0, rob_rs2_value_i = '0;
    logic cdb_valid_i = 0;
    logic [ROB_IDX_LEN-1:0] cdb_rob_idx_i = '0;
    logic [XLEN-1:0] cdb_value_i = '0;
    logic [EU_N-1:0] ex_ready_i = '0, ex_valid_o;
    logic [EU_CTL_LEN-1:0] ex_eu_ctl_o;
    logic ex_rs1_ready_o, ex_rs2_ready_o;
    logic [ROB_IDX_LEN-1:0] ex_rs1_tag_o, ex_rs2_tag_o, ex_rob_idx_o;
    logic [XLEN-1:0] ex_rs1_value_o, ex_rs2_value_o, ex_imm_o, ex_pc_o;

    logic [15:0] lfsr = 16'd31;
    logic [XLEN-1:0] exp_pc_q[$];      // Accepted but not yet issued
    logic [ILEN-1:0] exp_instr_q[$];
    logic [31:0] mon_w, mon_p;
    logic [31:0] next_pc = 32'h1000;
    logic env_random = 0;              // Random ROB, unit and operand answers
    int checks = 0, errors = 0, issued = 0, tests = 0, hold;
    string test_name = "reset";

    issue_stage i_issue_stage (.*);
    bind issue_stage issue_stage_assertions u_issue_stage_assertions (.*);

    initial forever #(PERIOD / 2) clk_i = ~clk_i;

    // --------------------------------------------------
    // Random source, 16-bit Galois LFSR
    // --------------------------------------------------
    function automatic logic [31:0] rand_bits(int n);
        logic [31:0] r = '0;
        for (int i = 0; i < n; i++) begin
            r = {r[30:0], lfsr[0]};
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 16'hB400) : (lfsr >> 1);  // One step per bit
        end
        return r;
    endfunction

    function automatic logic [31:0] gen_legal();
        logic [6:0] op;
        case (rand_bits(3) % 6)
            0: op = OPC_OP;
            1: op = OPC_OP_IMM;
            2: op = OPC_LUI;
            3: op = OPC_LOAD;
            4: op = OPC_STORE;
            default: op = OPC_BRANCH;
        endcase
        return {rand_bits(25), op};
    endfunction

    // --------------------------------------------------
    // Reference decode from the ISA bit positions
    // --------------------------------------------------
    function automatic logic [2:0] ref_unit(logic [31:0] w);
        case (w[6:0])
            OPC_OP, OPC_OP_IMM, OPC_LUI: return 3'b001;
            OPC_BRANCH:                  return 3'b010;
            OPC_LOAD, OPC_STORE:         return 3'b100;
            default:                     return 3'b000;  // ROB only
        endcase
    endfunction

    function automatic logic [31:0] ref_imm(logic [31:0] w);
        case (w[6:0])
            OPC_OP_IMM, OPC_LOAD: return {{20{w[31]}}, w[31:20]};
            OPC_STORE:  return {{20{w[31]}}, w[31:25], w[11:7]};
            OPC_BRANCH: return {{19{w[31]}}, w[31], w[7], w[30:25], w[11:8], 1'b0};
            OPC_LUI:    return {w[31:12], 12'h000};
            default:    return 32'h0;
        endcase
    endfunction

    function automatic logic [3:0] ref_ctl(logic [31:0] w);
        if (w[6:0] == OPC_OP) return {w[30], w[14:12]};
        return {w[6:0] == OPC_STORE, w[14:12]};
    endfunction

    task automatic check(string what, logic [31:0] exp, logic [31:0] act);
        checks++;
        if (exp !== act) begin
            errors++;
            $display("CHECK FAILED %s %s: expected %h, actual %h", test_name, what, exp, act);
        end
    endtask

    // Resolver rule RF, then ROB, then CDB, else wait on the tag
    task automatic check_operand(string src, logic used, logic busy, logic [2:0] idx,
                                 logic [31:0] rf, logic robr, logic [31:0] robv,
                                 logic rdy, logic [2:0] tag, logic [31:0] val);
        logic e_rdy;
        logic [31:0] e_val;
        e_rdy = 1'b1;
        if (!(busy && used)) e_val = rf;
        else if (robr) e_val = robv;
        else if (cdb_valid_i && cdb_rob_idx_i == idx) e_val = cdb_value_i;
        else begin
            e_rdy = 1'b0;
            e_val = '0;
        end
        check({src, " ready"}, e_rdy, rdy);
        check({src, " value"}, e_val, val);
        if (!e_rdy) check({src, " tag"}, idx, tag);
    endtask

    // --------------------------------------------------
    // ROB and unit model, checks every issue
    // --------------------------------------------------
    always @(posedge clk_i) begin
        if (!rst_i) begin
            if (rob_valid_o && rob_ready_i) begin
                if (exp_pc_q.size() == 0) begin
                    errors++;
                    $display("ROB valid for pc %h with nothing pending", ex_pc_o);
                end else if (ref_unit(exp_instr_q[0]) == 0
                             || (ref_unit(exp_instr_q[0]) & ex_ready_i) != 0) begin
                    mon_w = exp_instr_q.pop_front();
                    mon_p = exp_pc_q.pop_front();
                    issued++;
                    check("pc", mon_p, ex_pc_o);
                    check("unit", ref_unit(mon_w), ex_valid_o);
                    check("illegal", ref_unit(mon_w) == 0 && mon_w[6:0] != OPC_SYSTEM
                          && mon_w[6:0] != OPC_FENCE, rob_illegal_o);
                    check("serial", mon_w[6:0] == OPC_SYSTEM || mon_w[6:0] == OPC_FENCE,
                          rob_serial_o);
                    if (ref_unit(mon_w) != 0) begin
                        check("ctl", ref_ctl(mon_w), ex_eu_ctl_o);
                        check("imm", ref_imm(mon_w), ex_imm_o);
                        check("rd", (mon_w[6:0] == OPC_STORE || mon_w[6:0] == OPC_BRANCH)
                              ? 0 : mon_w[11:7], rob_rd_idx_o);
                        check("rs1 idx", (mon_w[6:0] != OPC_LUI) ? mon_w[19:15] : 0,
                              rs1_idx_o);
                        check("rs2 idx", (mon_w[6:0] inside {OPC_OP, OPC_STORE, OPC_BRANCH})
                              ? mon_w[24:20] : 0, rs2_idx_o);
                        check("rob idx", rob_tail_idx_i, ex_rob_idx_o);
                        check_operand("rs1", mon_w[6:0] != OPC_LUI, rs1_busy_i, rs1_rob_idx_i,
                                      rf_rs1_value_i, rob_rs1_ready_i, rob_rs1_value_i,
                                      ex_rs1_ready_o, ex_rs1_tag_o, ex_rs1_value_o);
                        check_operand("rs2", mon_w[6:0] inside {OPC_OP, OPC_STORE, OPC_BRANCH},
                                      rs2_busy_i, rs2_rob_idx_i, rf_rs2_value_i,
                                      rob_rs2_ready_i, rob_rs2_value_i,
                                      ex_rs2_ready_o, ex_rs2_tag_o, ex_rs2_value_o);
                    end
                end
            end
            if (fetch_valid_i && fetch_ready_o && !flush_i) begin
                exp_pc_q.push_back(fetch_pc_i);
                exp_instr_q.push_back(fetch_instr_i);
            end
            if (flush_i) begin
                exp_pc_q.delete();     // Nothing held may issue afterwards
                exp_instr_q.delete();
            end
        end
    end

    // Random environment answers, driven on the falling edge
    always @(negedge clk_i) begin
        if (env_random) begin
            rob_ready_i     = rand_bits(2) != 0;
            ex_ready_i      = rand_bits(3) | rand_bits(3);
            rs1_busy_i      = rand_bits(1);
            rs2_busy_i      = rand_bits(1);
            rs1_rob_idx_i   = rand_bits(3);
            rs2_rob_idx_i   = rand_bits(3);
            rob_rs1_ready_i = rand_bits(1);
            rob_rs2_ready_i = rand_bits(1);
            cdb_valid_i     = rand_bits(1);
            cdb_rob_idx_i   = rand_bits(1) ? rs1_rob_idx_i : rand_bits(3);  // Frequent hits
            rf_rs1_value_i  = rand_bits(32);
            rf_rs2_value_i  = rand_bits(32);
            rob_rs1_value_i = rand_bits(32);
            rob_rs2_value_i = rand_bits(32);
            cdb_value_i     = rand_bits(32);
            rob_tail_idx_i  = rand_bits(3);
        end
    end

    // --------------------------------------------------
    // Fetch driver and test steps
    // --------------------------------------------------
    task automatic send(logic [31:0] w);
        logic accepted;
        fetch_valid_i = 1'b1;
        fetch_pc_i    = next_pc;
        fetch_instr_i = w;
        do begin
            accepted = fetch_ready_o;   // Stable until the next rising edge
            @(negedge clk_i);
        end while (!accepted);
        fetch_valid_i = 1'b0;
        next_pc += 4;
    endtask

    task automatic wait_drain();
        while (exp_pc_q.size() != 0) @(negedge clk_i);
    endtask

    task automatic finish_test();
        tests++;
        $display("test %s done, issued %0d, errors so far %0d", test_name, issued, errors);
    endtask

    initial begin
        #(WATCHDOG);
        $display("Timeout: run did not finish within %0d ns", WATCHDOG);
        $display("TEST FAILED");
        $finish;
    end

    initial begin
        repeat (2) @(negedge clk_i);
        rst_i = 0;

        test_name  = "random_order";
        env_random = 1;
        for (int i = 0; i < N_RANDOM; i++) send(gen_legal());
        wait_drain();
        @(negedge clk_i);
        env_random = 0;
        rs1_busy_i = 0;
        rs2_busy_i = 0;
        finish_test();

        test_name   = "backpressure";
        rob_ready_i = 0;
        ex_ready_i  = '1;
        hold        = issued;
        for (int i = 0; i < 4; i++) send({rand_bits(25), OPC_OP_IMM});
        check("fetch ready when full", 0, fetch_ready_o);
        rob_ready_i = 1;
        ex_ready_i  = '0;       // ROB ready, unit not
        repeat (4) @(negedge clk_i);
        check("issued under backpressure", hold, issued);
        ex_ready_i = '1;
        wait_drain();
        finish_test();

        test_name   = "serial_illegal";
        rob_ready_i = 0;
        send(32'h0000_0073);                 // ECALL
        send({rand_bits(25), OPC_OP});       // Waits behind the ECALL
        hold        = issued;
        rob_ready_i = 1;
        repeat (4) begin
            @(negedge clk_i);
            check("fetch ready while stalled", 0, fetch_ready_o);
        end
        check("issued while stalled", hold + 1, issued);
        resume_i = 1;
        @(negedge clk_i);
        resume_i = 0;
        send({rand_bits(25), 7'b1111111});   // Unknown opcode
        wait_drain();
        check("issued after resume", hold + 3, issued);
        finish_test();

        test_name   = "flush";
        rob_ready_i = 0;
        for (int i = 0; i < 4; i++) send(gen_legal());
        check("fetch ready before flush", 0, fetch_ready_o);
        hold    = issued;
        flush_i = 1;
        @(negedge clk_i);
        flush_i = 0;
        check("fetch ready after flush", 1, fetch_ready_o);
        rob_ready_i = 1;
        repeat (6) @(negedge clk_i);
        check("issued after flush", hold, issued);
        finish_test();

        errors += i_issue_stage.u_issue_stage_assertions.assert_errors;
        $display("tests %0d, checks %0d, issued %0d, errors %0d",
                 tests, checks, issued, errors);
        if (errors == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule
